// ==== source/rv_core_defs.svh ====
// width, depth and reset constants for the core
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// RV64 data path
`define XLEN 64

// x0..x31
`define REG_AW 5

`define IMEM_AW 6 // 64 instruction words
`define DMEM_AW 5 // 32 doublewords

// first fetch address after reset
`define RESET_PC 64'h0

`endif

// ==== source/rv_core_pkg.sv ====
// enums for opcodes, ALU operation, branch kind, memory operation and ALU B source
`default_nettype none
`include "rv_core_defs.svh"

package rv_core_pkg;

  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_COPYB  = 4'b0011, // pass operand b through for lui
    ALU_SUB    = 4'b1000,
    ALU_ADDW   = 4'b1001, // add then sign-extend low word
    ALU_SLTU   = 4'b1010,
    ALU_EBREAK = 4'b1110,
    ALU_NOP    = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101
  } branch_e;

  typedef enum logic [2:0] {
    MEM_W    = 3'b100, // signed word
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10 // return address pc+4
  } bsrc_e;

endpackage

`default_nettype wire

// ==== source/rv_fetch.sv ====
// program counter, next-pc select, halt flag and loadable instruction memory
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_fetch (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_run,
  input  logic                i_imem_we,
  input  logic [`IMEM_AW-1:0] i_imem_addr,
  input  logic [31:0]         i_imem_data,
  input  logic                i_taken,
  input  logic [`XLEN-1:0]    i_target,
  input  logic                i_ebreak,
  output logic [`XLEN-1:0]    o_pc,
  output logic [31:0]         o_inst,
  output logic                o_halt,
  output logic                o_retire
);

  logic [`XLEN-1:0] pc;
  logic             halt;
  logic             step;
  logic [31:0]      imem [0:(1 << `IMEM_AW)-1];

  assign step     = i_run & ~halt;
  assign o_retire = step; // one instruction retires per stepping cycle
  assign o_pc     = pc;
  assign o_halt   = halt;
  assign o_inst   = imem[pc[`IMEM_AW+1:2]]; // word address

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc   <= `RESET_PC;
      halt <= 1'b0;
    end else if (step) begin
      if (i_ebreak) begin
        halt <= 1'b1; // pc stays on the ebreak
      end else begin
        pc <= i_taken ? i_target : pc + `XLEN'd4;
      end
    end
  end

  // program load port
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/rv_idu.sv ====
// instruction decoder for register fields, immediate and control enums
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_idu (
  input  logic [31:0]            i_inst,
  output logic [`XLEN-1:0]       o_imm,
  output logic [`REG_AW-1:0]     o_ra,
  output logic [`REG_AW-1:0]     o_rb,
  output logic [`REG_AW-1:0]     o_rd,
  output rv_core_pkg::branch_e   o_branch,
  output logic                   o_reg_wr,
  output logic                   o_alu_asrc,
  output rv_core_pkg::bsrc_e     o_alu_bsrc,
  output rv_core_pkg::alu_op_e   o_alu_op,
  output logic                   o_mem_to_reg,
  output logic                   o_mem_wr,
  output rv_core_pkg::mem_op_e   o_mem_op
);

  import rv_core_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(`XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  logic inst_lui, inst_auipc, inst_jal, inst_jalr, inst_beq, inst_bne;
  logic inst_lw, inst_sw, inst_sd, inst_addi, inst_sltiu, inst_addiw;
  logic inst_add, inst_sub, inst_addw, inst_ebreak;

  assign inst_lui    = (opcode == OPC_LUI);
  assign inst_auipc  = (opcode == OPC_AUIPC);
  assign inst_jal    = (opcode == OPC_JAL);
  assign inst_jalr   = (opcode == OPC_JALR) && (funct3 == 3'b000);
  assign inst_beq    = (opcode == OPC_BRANCH) && (funct3 == 3'b000);
  assign inst_bne    = (opcode == OPC_BRANCH) && (funct3 == 3'b001);
  assign inst_lw     = (opcode == OPC_LOAD) && (funct3 == 3'b010);
  assign inst_sw     = (opcode == OPC_STORE) && (funct3 == 3'b010);
  assign inst_sd     = (opcode == OPC_STORE) && (funct3 == 3'b011);
  assign inst_addi   = (opcode == OPC_OP_IMM) && (funct3 == 3'b000);
  assign inst_sltiu  = (opcode == OPC_OP_IMM) && (funct3 == 3'b011);
  assign inst_addiw  = (opcode == OPC_OP_IMM_32) && (funct3 == 3'b000);
  assign inst_add    = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign inst_sub    = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign inst_addw   = (opcode == OPC_OP_32) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign inst_ebreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000);

  // instruction formats
  logic type_r, type_i, type_u, type_s, type_b, type_j;
  assign type_r = inst_add | inst_sub | inst_addw;
  assign type_i = inst_lw | inst_addi | inst_sltiu | inst_addiw | inst_ebreak | inst_jalr;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sw | inst_sd;
  assign type_b = inst_beq | inst_bne;
  assign type_j = inst_jal;

  always_comb begin
    if (type_i)      o_imm = imm_i;
    else if (type_u) o_imm = imm_u;
    else if (type_s) o_imm = imm_s;
    else if (type_b) o_imm = imm_b;
    else if (type_j) o_imm = imm_j;
    else             o_imm = '0; // r-type and unknown
  end

  assign o_reg_wr     = type_r | (type_i & ~inst_ebreak) | type_u | type_j; // ebreak has no rd
  assign o_alu_asrc   = inst_jal | inst_auipc | inst_jalr; // 1 selects pc
  assign o_mem_to_reg = inst_lw;
  assign o_mem_wr     = type_s;

  always_comb begin
    if (inst_jal | inst_jalr)           o_alu_bsrc = BSRC_FOUR;
    else if (type_i | type_u | type_s) o_alu_bsrc = BSRC_IMM;
    else                                o_alu_bsrc = BSRC_RS2;

    if (inst_lw | inst_sw) o_mem_op = MEM_W;
    else if (inst_sd)      o_mem_op = MEM_D;
    else                   o_mem_op = MEM_NONE;

    if (inst_lui)                                   o_alu_op = ALU_COPYB;
    else if (inst_auipc | inst_jal | inst_jalr | inst_lw |
             inst_sw | inst_sd | inst_addi | inst_add) o_alu_op = ALU_ADD;
    else if (inst_addiw | inst_addw)                o_alu_op = ALU_ADDW;
    else if (type_b | inst_sub)                     o_alu_op = ALU_SUB; // branches compare by difference
    else if (inst_sltiu)                            o_alu_op = ALU_SLTU;
    else if (inst_ebreak)                           o_alu_op = ALU_EBREAK;
    else                                            o_alu_op = ALU_NOP;

    if (inst_jal)       o_branch = BR_JAL;
    else if (inst_jalr) o_branch = BR_JALR;
    else if (inst_beq)  o_branch = BR_BEQ;
    else if (inst_bne)  o_branch = BR_BNE;
    else                o_branch = BR_NONE;
  end

endmodule

`default_nettype wire

// ==== source/rv_regfile.sv ====
// 32 x XLEN register file, two async read ports, one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_regfile (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_we,
  input  logic [`REG_AW-1:0] i_waddr,
  input  logic [`XLEN-1:0]   i_wdata,
  input  logic [`REG_AW-1:0] i_raddr_a,
  input  logic [`REG_AW-1:0] i_raddr_b,
  output logic [`XLEN-1:0]   o_rdata_a,
  output logic [`XLEN-1:0]   o_rdata_b
);

  logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < (1 << `REG_AW); i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== source/rv_exec.sv ====
// ALU, branch resolve, data memory and write-back select
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_exec (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_step,
  input  logic [`XLEN-1:0]     i_pc,
  input  logic [`XLEN-1:0]     i_imm,
  input  logic [`XLEN-1:0]     i_rs1,
  input  logic [`XLEN-1:0]     i_rs2,
  input  rv_core_pkg::branch_e i_branch,
  input  logic                 i_reg_wr,
  input  logic                 i_alu_asrc,
  input  rv_core_pkg::bsrc_e   i_alu_bsrc,
  input  rv_core_pkg::alu_op_e i_alu_op,
  input  logic                 i_mem_to_reg,
  input  logic                 i_mem_wr,
  input  rv_core_pkg::mem_op_e i_mem_op,
  output logic                 o_wb_en,
  output logic [`XLEN-1:0]     o_wb_data,
  output logic                 o_taken,
  output logic [`XLEN-1:0]     o_target,
  output logic                 o_ebreak
);

  import rv_core_pkg::*;

  logic [`XLEN-1:0]    op_a, op_b, sum, alu_res;
  logic                zero;
  logic [`DMEM_AW-1:0] daddr;
  logic                word_sel;
  logic [`XLEN-1:0]    dword, load_data;
  logic [31:0]         word;
  logic [`XLEN-1:0]    dmem [0:(1 << `DMEM_AW)-1];

  assign op_a = i_alu_asrc ? i_pc : i_rs1;

  always_comb begin
    case (i_alu_bsrc)
      BSRC_RS2:  op_b = i_rs2;
      BSRC_IMM:  op_b = i_imm;
      BSRC_FOUR: op_b = `XLEN'd4;
      default:   op_b = '0;
    endcase
  end

  assign sum = op_a + op_b;

  always_comb begin
    case (i_alu_op)
      ALU_COPYB: alu_res = op_b;
      ALU_ADD:   alu_res = sum;
      ALU_ADDW:  alu_res = {{(`XLEN-32){sum[31]}}, sum[31:0]};
      ALU_SUB:   alu_res = op_a - op_b;
      ALU_SLTU:  alu_res = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
      default:   alu_res = '0; // ebreak and nop
    endcase
  end

  assign zero     = (alu_res == '0);
  assign o_ebreak = (i_alu_op == ALU_EBREAK);

  always_comb begin
    case (i_branch)
      BR_JAL, BR_JALR: o_taken = 1'b1;
      BR_BEQ:          o_taken = zero;
      BR_BNE:          o_taken = ~zero;
      default:         o_taken = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign o_target = (i_branch == BR_JALR) ? ((i_rs1 + i_imm) & ~`XLEN'd1) : (i_pc + i_imm);

  assign daddr    = alu_res[`DMEM_AW+2:3];
  assign word_sel = alu_res[2]; // upper word of the doubleword
  assign dword    = dmem[daddr];
  assign word     = word_sel ? dword[63:32] : dword[31:0];

  always_comb begin
    case (i_mem_op)
      MEM_W:   load_data = {{(`XLEN-32){word[31]}}, word};
      default: load_data = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst_n && i_step && i_mem_wr) begin
      if (i_mem_op == MEM_D) begin
        dmem[daddr] <= i_rs2;
      end else if (i_mem_op == MEM_W) begin
        if (word_sel) dmem[daddr][63:32] <= i_rs2[31:0];
        else          dmem[daddr][31:0]  <= i_rs2[31:0];
      end
    end
  end

  assign o_wb_en   = i_reg_wr & i_step;
  assign o_wb_data = i_mem_to_reg ? load_data : alu_res;

endmodule

`default_nettype wire

// ==== source/rv_core_top.sv ====
// core top wiring fetch, decode, register file and execute
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_core_top (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_run,
  input  logic                i_imem_we,
  input  logic [`IMEM_AW-1:0] i_imem_addr,
  input  logic [31:0]         i_imem_data,
  output logic                o_retire,
  output logic [`XLEN-1:0]    o_pc,
  output logic [31:0]         o_inst,
  output logic                o_wb_en,
  output logic [`REG_AW-1:0]  o_wb_rd,
  output logic [`XLEN-1:0]    o_wb_data,
  output logic                o_halt
);

  import rv_core_pkg::*;

  logic [`XLEN-1:0]   imm, rs1_val, rs2_val, target;
  logic [`REG_AW-1:0] ra, rb;
  branch_e            branch;
  bsrc_e              alu_bsrc;
  alu_op_e            alu_op;
  mem_op_e            mem_op;
  logic               reg_wr, alu_asrc, mem_to_reg, mem_wr, taken, ebreak;

  rv_fetch u_fetch (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run),
    .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
    .i_taken(taken), .i_target(target), .i_ebreak(ebreak),
    .o_pc(o_pc), .o_inst(o_inst), .o_halt(o_halt), .o_retire(o_retire)
  );

  rv_idu u_idu (
    .i_inst(o_inst), .o_imm(imm), .o_ra(ra), .o_rb(rb), .o_rd(o_wb_rd),
    .o_branch(branch), .o_reg_wr(reg_wr), .o_alu_asrc(alu_asrc), .o_alu_bsrc(alu_bsrc),
    .o_alu_op(alu_op), .o_mem_to_reg(mem_to_reg), .o_mem_wr(mem_wr), .o_mem_op(mem_op)
  );

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(o_wb_en), .i_waddr(o_wb_rd),
    .i_wdata(o_wb_data), .i_raddr_a(ra), .i_raddr_b(rb),
    .o_rdata_a(rs1_val), .o_rdata_b(rs2_val)
  );

  rv_exec u_exec (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(o_retire), .i_pc(o_pc), .i_imm(imm),
    .i_rs1(rs1_val), .i_rs2(rs2_val), .i_branch(branch), .i_reg_wr(reg_wr),
    .i_alu_asrc(alu_asrc), .i_alu_bsrc(alu_bsrc), .i_alu_op(alu_op),
    .i_mem_to_reg(mem_to_reg), .i_mem_wr(mem_wr), .i_mem_op(mem_op),
    .o_wb_en(o_wb_en), .o_wb_data(o_wb_data), .o_taken(taken), .o_target(target),
    .o_ebreak(ebreak)
  );

endmodule

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
// testbench for rv_core_top with program builder, LFSR, reference model, assertions and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module tb_rv_core;

  logic                clk, rst_n, i_run, i_imem_we;
  logic [`IMEM_AW-1:0] i_imem_addr;
  logic [31:0]         i_imem_data, o_inst;
  logic                o_retire, o_wb_en, o_halt;
  logic [`XLEN-1:0]    o_pc, o_wb_data;
  logic [`REG_AW-1:0]  o_wb_rd;

  rv_core_top dut0 (
    .i_clk(clk), .i_rst_n(rst_n), .i_run(i_run), .i_imem_we(i_imem_we),
    .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data), .o_retire(o_retire),
    .o_pc(o_pc), .o_inst(o_inst), .o_wb_en(o_wb_en), .o_wb_rd(o_wb_rd),
    .o_wb_data(o_wb_data), .o_halt(o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  string       test_name = "reset";
  logic [15:0] lfsr_state = 16'd61;
  logic [31:0] progs [0:2][0:63];
  int          lens [0:2];
  int          total_words;
  logic        prog_ready = 1'b0;

  // reference model state
  logic [63:0] m_regs [0:31];
  logic [63:0] m_mem [0:31];
  logic [31:0] m_prog [0:63];
  logic [63:0] m_pc;
  logic        m_halt, m_step;
  logic        e_wb_en, e_halt, e_st_w, e_st_d;
  logic [4:0]  e_rd;
  logic [31:0] e_inst;
  logic [63:0] e_data, e_next, e_addr, e_rs2v;

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 16'hB400; // x^16+x^14+x^13+x^11+1
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // expected effect of the instruction at the model pc by the ISA rules
  always_comb begin
    logic [31:0] ins;
    logic [63:0] rs1v, imm_i, imm_s, imm_b, imm_u, imm_j, dw;
    ins    = m_prog[m_pc[7:2]];
    e_inst = ins;
    rs1v   = m_regs[ins[19:15]];
    e_rs2v = m_regs[ins[24:20]];
    imm_i  = {{52{ins[31]}}, ins[31:20]};
    imm_s  = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b  = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u  = {{32{ins[31]}}, ins[31:12], 12'b0};
    imm_j  = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    e_rd = ins[11:7];
    e_wb_en = 1'b0;
    e_data = '0;
    e_next = m_pc + 64'd4;
    e_halt = 1'b0;
    e_st_w = 1'b0;
    e_st_d = 1'b0;
    e_addr = rs1v + imm_s;
    dw = '0;
    case (ins[6:0])
      7'h37: begin e_wb_en = 1'b1; e_data = imm_u; end
      7'h17: begin e_wb_en = 1'b1; e_data = m_pc + imm_u; end
      7'h6f: begin e_wb_en = 1'b1; e_data = m_pc + 64'd4; e_next = m_pc + imm_j; end
      7'h67: if (ins[14:12] == 3'd0) begin
        e_wb_en = 1'b1;
        e_data  = m_pc + 64'd4;
        e_next  = (rs1v + imm_i) & ~64'd1;
      end
      7'h63: begin
        if (ins[14:12] == 3'd0 && rs1v == e_rs2v) e_next = m_pc + imm_b;
        if (ins[14:12] == 3'd1 && rs1v != e_rs2v) e_next = m_pc + imm_b;
      end
      7'h03: if (ins[14:12] == 3'd2) begin
        e_addr  = rs1v + imm_i;
        dw      = m_mem[e_addr[7:3]];
        e_wb_en = 1'b1;
        e_data  = e_addr[2] ? {{32{dw[63]}}, dw[63:32]} : {{32{dw[31]}}, dw[31:0]};
      end
      7'h23: begin
        e_st_w = (ins[14:12] == 3'd2);
        e_st_d = (ins[14:12] == 3'd3);
      end
      7'h13: begin
        e_wb_en = (ins[14:12] == 3'd0) || (ins[14:12] == 3'd3);
        e_data  = (ins[14:12] == 3'd0) ? rs1v + imm_i : {63'd0, rs1v < imm_i};
      end
      7'h1b: if (ins[14:12] == 3'd0) begin
        dw      = rs1v + imm_i;
        e_wb_en = 1'b1;
        e_data  = {{32{dw[31]}}, dw[31:0]};
      end
      7'h33: if (ins[14:12] == 3'd0 && (ins[31:25] == 7'h00 || ins[31:25] == 7'h20)) begin
        e_wb_en = 1'b1;
        e_data  = ins[30] ? rs1v - e_rs2v : rs1v + e_rs2v;
      end
      7'h3b: if (ins[14:12] == 3'd0 && ins[31:25] == 7'h00) begin
        dw      = rs1v + e_rs2v;
        e_wb_en = 1'b1;
        e_data  = {{32{dw[31]}}, dw[31:0]};
      end
      7'h73: if (ins[14:12] == 3'd0) begin e_halt = 1'b1; e_next = m_pc; end
      default: ;
    endcase
  end

  assign m_step = i_run && !m_halt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) m_regs[i] <= '0;
      m_pc   <= `RESET_PC;
      m_halt <= 1'b0;
    end else if (m_step) begin
      if (e_wb_en && e_rd != 5'd0) m_regs[e_rd] <= e_data;
      if (e_st_d) m_mem[e_addr[7:3]] <= e_rs2v;
      if (e_st_w && e_addr[2]) m_mem[e_addr[7:3]][63:32] <= e_rs2v[31:0];
      if (e_st_w && !e_addr[2]) m_mem[e_addr[7:3]][31:0] <= e_rs2v[31:0];
      m_pc <= e_next;
      if (e_halt) m_halt <= 1'b1;
    end
  end

  task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("Error %s %s: expected %h actual %h", test_name, what, exp, act);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  a_retire: assert property (@(posedge clk) disable iff (!rst_n) o_retire == m_step)
    else fail_value("retire", 64'($sampled(m_step)), 64'($sampled(o_retire)));
  a_pc: assert property (@(posedge clk) disable iff (!rst_n) o_pc == m_pc)
    else fail_value("pc", $sampled(m_pc), $sampled(o_pc));
  a_inst: assert property (@(posedge clk) disable iff (!rst_n) o_retire |-> o_inst == e_inst)
    else fail_value("inst", 64'($sampled(e_inst)), 64'($sampled(o_inst)));
  a_halt: assert property (@(posedge clk) disable iff (!rst_n) o_halt == m_halt)
    else fail_value("halt", 64'($sampled(m_halt)), 64'($sampled(o_halt)));
  a_wb_en: assert property (@(posedge clk) disable iff (!rst_n) o_retire |-> o_wb_en == e_wb_en)
    else fail_value("wb_en", 64'($sampled(e_wb_en)), 64'($sampled(o_wb_en)));
  a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
      (o_retire && e_wb_en) |-> o_wb_rd == e_rd)
    else fail_value("wb_rd", 64'($sampled(e_rd)), 64'($sampled(o_wb_rd)));
  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
      (o_retire && e_wb_en) |-> o_wb_data == e_data)
    else fail_value("wb_data", $sampled(e_data), $sampled(o_wb_data));

  task automatic build_programs();
    int n;
    logic [11:0] a;
    n = 0;
    progs[0][n++] = enc_i(12'd5, 5'd0, 3'd0, 5'd0, 7'h13); // addi x0 must stay zero
    progs[0][n++] = enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, 7'h33);
    for (int k = 0; k < 40; k++) begin
      case (rand_bits(3))
        0: progs[0][n++] = {20'(rand_bits(20)), 5'(rand_bits(3)), 7'h37};
        1: progs[0][n++] = {20'(rand_bits(20)), 5'(rand_bits(3)), 7'h17};
        2: progs[0][n++] = enc_i(12'(rand_bits(12)), 5'(rand_bits(3)), 3'd0, 5'(rand_bits(3)), 7'h13);
        3: progs[0][n++] = enc_i(12'(rand_bits(12)), 5'(rand_bits(3)), 3'd3, 5'(rand_bits(3)), 7'h13);
        4: progs[0][n++] = enc_i(12'(rand_bits(12)), 5'(rand_bits(3)), 3'd0, 5'(rand_bits(3)), 7'h1b);
        5: progs[0][n++] = enc_r(7'h00, 5'(rand_bits(3)), 5'(rand_bits(3)), 3'd0, 5'(rand_bits(3)), 7'h33);
        6: progs[0][n++] = enc_r(7'h20, 5'(rand_bits(3)), 5'(rand_bits(3)), 3'd0, 5'(rand_bits(3)), 7'h33);
        default: progs[0][n++] = enc_r(7'h00, 5'(rand_bits(3)), 5'(rand_bits(3)), 3'd0,
                                       5'(rand_bits(3)), 7'h3b);
      endcase
    end
    progs[0][n++] = 32'h00100073;
    lens[0] = n;
    n = 0;
    for (int k = 0; k < 6; k++) begin
      a = {4'd0, 5'(rand_bits(5)), 3'd0}; // doubleword aligned
      progs[1][n++] = enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd5, 7'h13);
      progs[1][n++] = {20'(rand_bits(20)), 5'd8, 7'h37};
      progs[1][n++] = enc_r(7'h00, 5'd8, 5'd5, 3'd0, 5'd5, 7'h33);
      progs[1][n++] = enc_s(a, 5'd5, 5'd0, 3'd3);
      progs[1][n++] = enc_i(a, 5'd0, 3'd2, 5'd6, 7'h03);
      progs[1][n++] = enc_i(a + 12'd4, 5'd0, 3'd2, 5'd7, 7'h03);
      progs[1][n++] = enc_s(a + 12'd4, 5'd6, 5'd0, 3'd2);
      progs[1][n++] = enc_i(a + 12'd4, 5'd0, 3'd2, 5'd9, 7'h03);
    end
    progs[1][n++] = 32'h00100073;
    lens[1] = n;
    progs[2][0]  = enc_i(12'd3, 5'd0, 3'd0, 5'd1, 7'h13);
    progs[2][1]  = enc_i(12'd3, 5'd0, 3'd0, 5'd2, 7'h13);
    progs[2][2]  = enc_b(13'd8, 5'd2, 5'd1, 3'd0); // beq taken
    progs[2][3]  = enc_i(12'd1, 5'd0, 3'd0, 5'd3, 7'h13);
    progs[2][4]  = enc_b(13'd8, 5'd2, 5'd1, 3'd1); // bne not taken
    progs[2][5]  = enc_b(13'd8, 5'd0, 5'd1, 3'd0); // beq not taken
    progs[2][6]  = enc_b(13'd8, 5'd0, 5'd1, 3'd1); // bne taken
    progs[2][7]  = enc_i(12'd2, 5'd0, 3'd0, 5'd3, 7'h13);
    progs[2][8]  = enc_j(21'd16, 5'd5);
    progs[2][9]  = enc_i(12'd9, 5'd0, 3'd0, 5'd6, 7'h13);
    progs[2][10] = 32'h00100073;
    progs[2][11] = enc_i(12'd4, 5'd0, 3'd0, 5'd3, 7'h13);
    progs[2][12] = enc_i(12'd1, 5'd5, 3'd0, 5'd7, 7'h67); // odd target with bit 0 dropped
    lens[2] = 13;
    total_words = lens[0] + lens[1] + lens[2];
  endtask

  task automatic run_program(input int p, input string name);
    test_name = name;
    @(posedge clk);
    i_run <= 1'b0;
    rst_n <= 1'b0;
    for (int i = 0; i < lens[p]; i++) begin
      @(posedge clk);
      i_imem_we   <= 1'b1;
      i_imem_addr <= 6'(i);
      i_imem_data <= progs[p][i];
      m_prog[i] = progs[p][i];
    end
    @(posedge clk);
    i_imem_we <= 1'b0;
    rst_n     <= 1'b1;
    repeat (3) @(posedge clk); // idle with run low
    i_run <= 1'b1;
    repeat (6) @(posedge clk);
    i_run <= 1'b0; // stall mid-program
    repeat (3) @(posedge clk);
    i_run <= 1'b1;
    wait (o_halt);
    repeat (4) @(posedge clk);
    i_run <= 1'b0;
  endtask

  initial begin
    rst_n       <= 1'b0;
    i_run       <= 1'b0;
    i_imem_we   <= 1'b0;
    i_imem_addr <= '0;
    i_imem_data <= '0;
    for (int i = 0; i < 64; i++) m_prog[i] = 32'h00100073;
    build_programs();
    prog_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    run_program(0, "arith");
    run_program(1, "memory");
    run_program(2, "control");
    $display("ALL TESTS PASSED");
    $finish;
  end

  // loading and running each take about one cycle per word
  initial begin
    wait (prog_ready);
    #((2 * total_words + 50) * 40);
    $display("timeout: the programs did not finish in time");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_idu.sv
source/rv_regfile.sv
source/rv_exec.sv
source/rv_core_top.sv
verif/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' sim.f) source/rv_core_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
